// ==== memCtrlPkg.sv ====
package memCtrlPkg;

  // Number of store ports feeding the single RAM write port
  localparam int numStores = 2;

  // Number of control token channels announcing store counts
  localparam int numControls = 1;

  // RAM word address
  typedef logic [31:0] addrT;

  // Store data word
  typedef logic [31:0] dataT;

  // Store count, used by the pending counter and the token payload
  typedef logic [31:0] countT;

  // Write command to the RAM port
  typedef struct packed {
    logic en;
    addrT addr;
    dataT data;
  } ramWriteT;

  // Completion sequencing of one basic block run
  typedef enum logic [1:0] {
    sIdle,
    sRunning,
    sDraining,
    sEnding
  } ctrlStateT;

endpackage

// ==== storeArbiter.sv ====
`timescale 1ns/100ps

module storeArbiter (
  input  logic                                                clk,
  input  logic                                                rst,
  input  memCtrlPkg::addrT [memCtrlPkg::numStores-1:0]        stAddr,
  input  logic             [memCtrlPkg::numStores-1:0]        stAddrValid,
  output logic             [memCtrlPkg::numStores-1:0]        stAddrReady,
  input  memCtrlPkg::dataT [memCtrlPkg::numStores-1:0]        stData,
  input  logic             [memCtrlPkg::numStores-1:0]        stDataValid,
  output logic             [memCtrlPkg::numStores-1:0]        stDataReady,
  output memCtrlPkg::ramWriteT                                ramWrite
);
  import memCtrlPkg::*;

  logic [numStores-1:0] grant;
  logic                 anyGrant;
  addrT                 selAddr;
  dataT                 selData;

  // Registered write command
  logic writeEn;
  addrT writeAddr;
  dataT writeData;

  // Fixed priority, port 0 wins
  always_comb begin
    grant    = '0;
    anyGrant = 1'b0;
    selAddr  = '0;
    selData  = '0;
    for (int i = 0; i < numStores; i++) begin
      if (!anyGrant && stAddrValid[i] && stDataValid[i]) begin
        anyGrant = 1'b1;
        grant[i] = 1'b1;
        selAddr  = stAddr[i];
        selData  = stData[i];
      end
    end
  end

  // Address and data are accepted together on the same grant
  assign stAddrReady = grant;
  assign stDataReady = grant;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      writeEn <= 1'b0;
    end else begin
      writeEn <= anyGrant;
    end
  end

  // Payload captured with each grant
  always_ff @(posedge clk) begin
    if (anyGrant) begin
      writeAddr <= selAddr;
      writeData <= selData;
    end
  end

  assign ramWrite = '{en: writeEn, addr: writeAddr, data: writeData};

  // Only one port may be accepted per cycle
  grantOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  );

  // An accepted store reaches the RAM port with a known address
  writeAddrKnown: assert property (
    @(posedge clk) disable iff (rst)
    ramWrite.en |-> !$isunknown(ramWrite.addr)
  );

endmodule

// ==== storeCounter.sv ====
`timescale 1ns/100ps

module storeCounter (
  input  logic                                            clk,
  input  logic                                            rst,
  input  memCtrlPkg::countT [memCtrlPkg::numControls-1:0] ctrl,
  input  logic              [memCtrlPkg::numControls-1:0] ctrlValid,
  input  memCtrlPkg::ramWriteT                            ramWrite,
  output logic                                            allDone
);
  import memCtrlPkg::*;

  countT count;
  countT nextCount;

  // Announced stores in, completed writes out
  always_comb begin
    nextCount = count;
    for (int i = 0; i < numControls; i++) begin
      if (ctrlValid[i]) begin
        nextCount = nextCount + ctrl[i];
      end
    end
    if (ramWrite.en) begin
      nextCount = nextCount - countT'(1);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else begin
      count <= nextCount;
    end
  end

  // A token arriving this cycle means more stores are on the way
  assign allDone = (count == '0) && (ctrlValid == '0);

  // A write with nothing pending would wrap the counter
  noUnderflow: assert property (
    @(posedge clk) disable iff (rst)
    ramWrite.en |-> (count != '0) || (ctrlValid != '0)
  );

endmodule

// ==== memCtrlControl.sv ====
`timescale 1ns/100ps

module memCtrlControl (
  input  logic clk,
  input  logic rst,
  input  logic memStartValid,
  output logic memStartReady,
  output logic memEndValid,
  input  logic memEndReady,
  input  logic ctrlEndValid,
  output logic ctrlEndReady,
  input  logic allDone
);
  import memCtrlPkg::*;

  ctrlStateT state;
  ctrlStateT nextState;

  always_comb begin
    nextState = state;
    case (state)
      sIdle: begin
        if (memStartValid) begin
          nextState = sRunning;
        end
      end
      sRunning: begin
        // No more requests will be issued in this block
        if (ctrlEndValid) begin
          nextState = sDraining;
        end
      end
      sDraining: begin
        // Wait for outstanding stores to land in the RAM
        if (allDone) begin
          nextState = sEnding;
        end
      end
      sEnding: begin
        if (memEndReady) begin
          nextState = sIdle;
        end
      end
      default: begin
        nextState = sIdle;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= sIdle;
    end else begin
      state <= nextState;
    end
  end

  // Handshake signals decode straight from the state
  assign memStartReady = (state == sIdle);
  assign ctrlEndReady  = (state == sRunning);
  assign memEndValid   = (state == sEnding);

  // End token is held until the consumer takes it
  endTokenHeld: assert property (
    @(posedge clk) disable iff (rst)
    memEndValid && !memEndReady |=> memEndValid
  );

endmodule

// ==== storeMemController.sv ====
`timescale 1ns/100ps

module storeMemController (
  input  logic                                            clk,
  input  logic                                            rst,
  // Start and end of a block run
  input  logic                                            memStartValid,
  output logic                                            memStartReady,
  output logic                                            memEndValid,
  input  logic                                            memEndReady,
  // No more requests token
  input  logic                                            ctrlEndValid,
  output logic                                            ctrlEndReady,
  // Store count announcements
  input  memCtrlPkg::countT [memCtrlPkg::numControls-1:0] ctrl,
  input  logic              [memCtrlPkg::numControls-1:0] ctrlValid,
  output logic              [memCtrlPkg::numControls-1:0] ctrlReady,
  // Store ports
  input  memCtrlPkg::addrT  [memCtrlPkg::numStores-1:0]   stAddr,
  input  logic              [memCtrlPkg::numStores-1:0]   stAddrValid,
  output logic              [memCtrlPkg::numStores-1:0]   stAddrReady,
  input  memCtrlPkg::dataT  [memCtrlPkg::numStores-1:0]   stData,
  input  logic              [memCtrlPkg::numStores-1:0]   stDataValid,
  output logic              [memCtrlPkg::numStores-1:0]   stDataReady,
  // RAM write port
  output memCtrlPkg::ramWriteT                            ramWrite
);

  logic allDone;

  // Tokens are always consumed on arrival
  assign ctrlReady = '1;

  storeArbiter u_storeArbiter (
    .clk         (clk),
    .rst         (rst),
    .stAddr      (stAddr),
    .stAddrValid (stAddrValid),
    .stAddrReady (stAddrReady),
    .stData      (stData),
    .stDataValid (stDataValid),
    .stDataReady (stDataReady),
    .ramWrite    (ramWrite)
  );

  storeCounter u_storeCounter (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .ctrlValid (ctrlValid),
    .ramWrite  (ramWrite),
    .allDone   (allDone)
  );

  memCtrlControl u_memCtrlControl (
    .clk           (clk),
    .rst           (rst),
    .memStartValid (memStartValid),
    .memStartReady (memStartReady),
    .memEndValid   (memEndValid),
    .memEndReady   (memEndReady),
    .ctrlEndValid  (ctrlEndValid),
    .ctrlEndReady  (ctrlEndReady),
    .allDone       (allDone)
  );

endmodule

// ==== tbStoreMemController.sv ====
`timescale 1ns/100ps

module tbStoreMemController;
  import memCtrlPkg::*;

  typedef struct packed {
    addrT addr;
    dataT data;
  } storeRecT;

  logic clk;
  logic rst;
  logic memStartValid;
  logic memStartReady;
  logic memEndValid;
  logic memEndReady;
  logic ctrlEndValid;
  logic ctrlEndReady;
  countT [numControls-1:0] ctrl;
  logic [numControls-1:0] ctrlValid;
  logic [numControls-1:0] ctrlReady;
  addrT [numStores-1:0] stAddr;
  logic [numStores-1:0] stAddrValid;
  logic [numStores-1:0] stAddrReady;
  dataT [numStores-1:0] stData;
  logic [numStores-1:0] stDataValid;
  logic [numStores-1:0] stDataReady;
  ramWriteT ramWrite;

  storeRecT observed[$];
  storeRecT expected[$];
  int valueErrors = 0;
  int timeoutErrors = 0;

  storeMemController u_storeMemController (
    .clk(clk), .rst(rst),
    .memStartValid(memStartValid), .memStartReady(memStartReady),
    .memEndValid(memEndValid), .memEndReady(memEndReady),
    .ctrlEndValid(ctrlEndValid), .ctrlEndReady(ctrlEndReady),
    .ctrl(ctrl), .ctrlValid(ctrlValid), .ctrlReady(ctrlReady),
    .stAddr(stAddr), .stAddrValid(stAddrValid), .stAddrReady(stAddrReady),
    .stData(stData), .stDataValid(stDataValid), .stDataReady(stDataReady),
    .ramWrite(ramWrite)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // RAM write monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && ramWrite.en === 1'b1) begin
      observed.push_back({ramWrite.addr, ramWrite.data});
    end
  end

  // Drive point, 10 ns after a rising edge
  task automatic nextCycle();
    @(posedge clk);
    #10;
  endtask

  // Combinational readies follow freshly driven valids after a short settle
  task automatic settle();
    #1;
  endtask

  task automatic reportValue(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    valueErrors++;
    $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
  endtask

  task automatic reportTimeout(input string what);
    timeoutErrors++;
    $display("Timeout at %0t ns: %s", $time, what);
  endtask

  // Start token, count announcement, then the no more requests token
  task automatic beginRun(input countT n);
    int waited;
    memStartValid = 1'b1;
    waited = 0;
    while (!memStartReady && waited < 20) begin
      nextCycle();
      waited++;
    end
    if (!memStartReady) reportTimeout("start token was never accepted");
    nextCycle();
    memStartValid = 1'b0;
    ctrl[0] = n;
    ctrlValid[0] = 1'b1;
    if (ctrlReady[0] !== 1'b1) reportValue("ctrlReady", 1, ctrlReady[0]);
    nextCycle();
    ctrlValid[0] = 1'b0;
    ctrl[0] = '0;
    ctrlEndValid = 1'b1;
    waited = 0;
    while (!ctrlEndReady && waited < 20) begin
      nextCycle();
      waited++;
    end
    if (!ctrlEndReady) reportTimeout("ctrlEnd token was never accepted");
    nextCycle();
    ctrlEndValid = 1'b0;
  endtask

  // One store on one port, write expected on the cycle after acceptance
  task automatic sendStore(input int port, input addrT addr, input dataT data);
    int waited;
    stAddr[port] = addr;
    stData[port] = data;
    stAddrValid[port] = 1'b1;
    stDataValid[port] = 1'b1;
    settle();
    waited = 0;
    while (!stAddrReady[port] && waited < 20) begin
      nextCycle();
      waited++;
    end
    if (!stAddrReady[port]) begin
      reportTimeout($sformatf("store port %0d was never granted", port));
      stAddrValid[port] = 1'b0;
      stDataValid[port] = 1'b0;
    end else begin
      if (stDataReady[port] !== 1'b1) reportValue("stDataReady", 1, stDataReady[port]);
      nextCycle();
      stAddrValid[port] = 1'b0;
      stDataValid[port] = 1'b0;
      expected.push_back({addr, data});
      if (ramWrite.en !== 1'b1) reportValue("ramWrite.en", 1, ramWrite.en);
      if (ramWrite.addr !== addr) reportValue("ramWrite.addr", addr, ramWrite.addr);
      if (ramWrite.data !== data) reportValue("ramWrite.data", data, ramWrite.data);
    end
  endtask

  // Wait for the end token, hold it off, then take it
  task automatic awaitEnd(input int holdCycles, input int maxWait);
    int waited;
    waited = 0;
    while (!memEndValid && waited < maxWait) begin
      nextCycle();
      waited++;
    end
    if (!memEndValid) begin
      reportTimeout("end token was not offered in time");
    end else begin
      for (int i = 0; i < holdCycles; i++) begin
        nextCycle();
        if (memEndValid !== 1'b1) reportValue("memEndValid", 1, memEndValid);
      end
      memEndReady = 1'b1;
      nextCycle();
      memEndReady = 1'b0;
      if (memEndValid !== 1'b0) reportValue("memEndValid", 0, memEndValid);
      if (memStartReady !== 1'b1) reportValue("memStartReady", 1, memStartReady);
    end
  endtask

  task automatic compareWrites();
    if (observed.size() != expected.size()) begin
      reportValue("write count", expected.size(), observed.size());
    end else begin
      for (int i = 0; i < expected.size(); i++) begin
        if (observed[i] !== expected[i]) begin
          reportValue($sformatf("write %0d addr/data", i), expected[i], observed[i]);
        end
      end
    end
    observed.delete();
    expected.delete();
  endtask

  task automatic checkResetState();
    if (ramWrite.en !== 1'b0) reportValue("ramWrite.en", 0, ramWrite.en);
    if (memEndValid !== 1'b0) reportValue("memEndValid", 0, memEndValid);
    if (ctrlEndReady !== 1'b0) reportValue("ctrlEndReady", 0, ctrlEndReady);
    if (memStartReady !== 1'b1) reportValue("memStartReady", 1, memStartReady);
    if (stAddrReady !== '0) reportValue("stAddrReady", 0, stAddrReady);
    if (stDataReady !== '0) reportValue("stDataReady", 0, stDataReady);
  endtask

  task automatic singleStore();
    beginRun(1);
    if (ramWrite.en !== 1'b0) reportValue("ramWrite.en", 0, ramWrite.en);
    sendStore(1, 32'h0000_1040, 32'hcafe_0001);
    nextCycle();
    if (ramWrite.en !== 1'b0) reportValue("ramWrite.en", 0, ramWrite.en);
    awaitEnd(0, 10);
    compareWrites();
  endtask

  // Both ports in the same cycle, port 0 goes first
  task automatic portPriority();
    beginRun(2);
    stAddr = {32'h0000_2004, 32'h0000_2000};
    stData = {32'hbeef_0011, 32'hbeef_0010};
    stAddrValid = 2'b11;
    stDataValid = 2'b11;
    settle();
    if (stAddrReady !== 2'b01) reportValue("stAddrReady", 2'b01, stAddrReady);
    if (stDataReady !== 2'b01) reportValue("stDataReady", 2'b01, stDataReady);
    nextCycle();
    stAddrValid[0] = 1'b0;
    stDataValid[0] = 1'b0;
    expected.push_back({32'h0000_2000, 32'hbeef_0010});
    if (ramWrite.addr !== 32'h0000_2000) reportValue("ramWrite.addr", 32'h2000, ramWrite.addr);
    if (ramWrite.data !== 32'hbeef_0010) reportValue("ramWrite.data", 32'hbeef_0010, ramWrite.data);
    settle();
    if (stAddrReady !== 2'b10) reportValue("stAddrReady", 2'b10, stAddrReady);
    nextCycle();
    stAddrValid = '0;
    stDataValid = '0;
    expected.push_back({32'h0000_2004, 32'hbeef_0011});
    if (ramWrite.addr !== 32'h0000_2004) reportValue("ramWrite.addr", 32'h2004, ramWrite.addr);
    if (ramWrite.data !== 32'hbeef_0011) reportValue("ramWrite.data", 32'hbeef_0011, ramWrite.data);
    awaitEnd(0, 10);
    compareWrites();
  endtask

  task automatic completionTiming();
    beginRun(4);
    for (int i = 0; i < 4; i++) begin
      repeat (2) begin
        nextCycle();
        if (memEndValid !== 1'b0) reportValue("memEndValid", 0, memEndValid);
      end
      sendStore(i % 2, 32'h0000_3000 + 4 * i, 32'h5a5a_0000 + i);
      if (memEndValid !== 1'b0) reportValue("memEndValid", 0, memEndValid);
    end
    // Count drains one cycle after the last write, end token one cycle later
    awaitEnd(0, 2);
    compareWrites();
  endtask

  task automatic endBackPressure();
    beginRun(2);
    sendStore(0, 32'h0000_4000, 32'h0bad_f00d);
    sendStore(1, 32'h0000_4004, 32'h0bad_f00e);
    awaitEnd(5, 10);
    compareWrites();
  endtask

  task automatic randomRun();
    countT n;
    int gap;
    n = $urandom_range(20, 1);
    beginRun(n);
    for (int i = 0; i < n; i++) begin
      if (memEndValid !== 1'b0) reportValue("memEndValid", 0, memEndValid);
      sendStore($urandom_range(numStores - 1, 0), $urandom, $urandom);
      gap = $urandom_range(2, 0);
      repeat (gap) nextCycle();
    end
    awaitEnd($urandom_range(3, 0), 10);
    compareWrites();
  endtask

  initial begin
    void'($urandom(32'h765c_e0e3));
    rst = 1'b1;
    memStartValid = 1'b0;
    memEndReady = 1'b0;
    ctrlEndValid = 1'b0;
    ctrl = '0;
    ctrlValid = '0;
    stAddr = '0;
    stAddrValid = '0;
    stData = '0;
    stDataValid = '0;
    repeat (10) @(posedge clk);
    #10;
    rst = 1'b0;
    nextCycle();
    checkResetState();
    singleStore();
    portPriority();
    completionTiming();
    endBackPressure();
    repeat (4) randomRun();
    nextCycle();
    $display("Value errors: %0d, timeouts: %0d", valueErrors, timeoutErrors);
    if (valueErrors == 0 && timeoutErrors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
memCtrlPkg.sv
storeArbiter.sv
storeCounter.sv
memCtrlControl.sv
storeMemController.sv
tbStoreMemController.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tbStoreMemController -Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "Simulation reported failure"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
